// File: sim.f
design/microrocPkg.sv
design/configRegs.sv
design/slowControlLoader.sv
design/daqControl.sv
design/ramReadOut.sv
design/holdGen.sv
design/microrocTop.sv
verification/microrocTop_props.sv
verification/microrocTb.sv

// File: run.sh
#!/bin/bash
# Build and run the Verilator simulation, fail status on any error
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module microrocTb -f sim.f --Mdir obj_dir

./obj_dir/VmicrorocTb | tee sim.log

if grep -q "Testbench failed" sim.log; then
   exit 1
fi
exit 0

// File: verification/microrocTb.sv
`timescale 1ns/10ps

module microrocTb import microrocPkg::*;;

   localparam int NumAsics     = 2;
   localparam int AckTimeout   = 20;    // Cycles per Wishbone access
   localparam int StateTimeout = 400;   // Cycles per DAQ state wait
   localparam int PollLimit    = 400;   // Status reads while loading
   localparam int HoldSpan     = 30;    // Observation window for hold
   localparam int NumWords     = 12;

   logic      Clk;
   logic      arstN;
   wbReq_t    wbReq;
   wbRsp_t    wbRsp;
   scPins_t   scPins;
   pwrOn_t    pwrOn;
   logic      startAcq, resetB, startReadout, hold;
   logic      chipSatB, endReadout, doutB, transmitOnB, fifoFull, trigIn;
   fifoWord_t fifoWord;

   int        errors, checks, rstLow;
   int        acqLen, winCycles, pwrBad, holdDly, holdWid, holdSeen;
   int        k, n, g, gap, polls, mismatches;
   regData_t  rd, rnd, evtBefore;
   scWord_t   scModel;           // Expected configuration
   logic [15:0] acqModel, holdModel;
   logic      holdExp;
   rawWord_t  w;
   logic      srCkQ = 1'b0;
   logic      scStream[$];       // srIn captured on srCk rise
   rawWord_t  txWords[$];        // Sent by the ASIC model
   rawWord_t  rxWords[$];        // Seen on the FIFO port

   microrocTop #(.numAsics(NumAsics)) i_dut (
      .Clk          (Clk),
      .arstN        (arstN),
      .wbReq        (wbReq),
      .wbRsp        (wbRsp),
      .scPins       (scPins),
      .pwrOn        (pwrOn),
      .startAcq     (startAcq),
      .resetB       (resetB),
      .chipSatB     (chipSatB),
      .startReadout (startReadout),
      .endReadout   (endReadout),
      .doutB        (doutB),
      .transmitOnB  (transmitOnB),
      .trigIn       (trigIn),
      .hold         (hold),
      .fifoFull     (fifoFull),
      .fifoWord     (fifoWord)
   );

   initial begin
      Clk = 1'b0;
      forever #2 Clk = ~Clk;          // 4 ns period
   end

   //////////////////////////////////////////////////
   // Monitors
   //////////////////////////////////////////////////
   always @(negedge Clk) begin
      if (scPins.select && scPins.srCk && !srCkQ) scStream.push_back(scPins.srIn);
      if (scPins.select && !scPins.srRstB) rstLow++;   // Chain reset length
      srCkQ = scPins.srCk;
   end

   always @(negedge Clk) begin
      if (fifoWord.valid) rxWords.push_back(fifoWord.data);   // Words in arrival order
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   task automatic reportTimeout(input string what);
      errors++;
      $display("Timeout while waiting for %s", what);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      $display("Testbench failed");
      $finish;
   endtask

   task automatic writeReg(input regAddr_t adr, input regData_t dat);
      int waited;
      waited = 0;
      @(posedge Clk);
      wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
      do begin
         @(negedge Clk);
         waited++;
      end while (!wbRsp.ack && waited < AckTimeout);
      if (!wbRsp.ack) reportTimeout("Wishbone write ack");
      @(posedge Clk);
      wbReq <= '0;                    // Release at the end of the ack cycle
   endtask

   task automatic readReg(input regAddr_t adr, output regData_t dat);
      int waited;
      waited = 0;
      @(posedge Clk);
      wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
      do begin
         @(negedge Clk);
         waited++;
      end while (!wbRsp.ack && waited < AckTimeout);
      dat = wbRsp.dat;                // Valid with ack
      if (!wbRsp.ack) reportTimeout("Wishbone read ack");
      @(posedge Clk);
      wbReq <= '0;
   endtask

   task automatic waitStartAcqLevel(input logic level);
      int waited;
      waited = 0;
      do begin
         @(negedge Clk);
         waited++;
      end while (startAcq !== level && waited < StateTimeout);
      if (startAcq !== level) reportTimeout("startAcq level");
   endtask

   task automatic waitPowerOff();
      int waited;
      waited = 0;
      do begin
         @(negedge Clk);
         waited++;
      end while (pwrOn !== 4'h0 && waited < StateTimeout);
      if (pwrOn !== 4'h0) reportTimeout("power enables to drop");
   endtask

   // ASIC model ends its readout after some latency
   task automatic pulseEndReadout(input int delay);
      repeat (delay) @(posedge Clk);
      endReadout <= 1'b1;
      @(posedge Clk);
      endReadout <= 1'b0;
   endtask

   // One RAM word, MSB first, active low on the wire
   task automatic sendSerialWord(input rawWord_t word, input logic full);
      for (int b = 15; b >= 0; b--) begin
         @(posedge Clk);
         transmitOnB <= 1'b0;
         doutB       <= ~word[b];
         fifoFull    <= full;
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus and checks
   //////////////////////////////////////////////////
   initial begin
      void'($urandom(73));
      errors      = 0;
      checks      = 0;
      rstLow      = 0;
      arstN       = 1'b0;
      wbReq       = '0;
      chipSatB    = 1'b1;
      endReadout  = 1'b0;
      doutB       = 1'b1;
      transmitOnB = 1'b1;
      fifoFull    = 1'b0;
      trigIn      = 1'b0;
      repeat (2) @(posedge Clk);
      arstN <= 1'b1;
      @(posedge Clk);

      // Register readback
      scModel = {$urandom, $urandom};
      writeReg(RegScLo, scModel[31:0]);
      writeReg(RegScHi, scModel[63:32]);
      rnd = $urandom;
      acqModel = rnd[15:0];
      writeReg(RegAcqTime, rnd);
      rnd = $urandom;
      holdModel = rnd[15:0];
      writeReg(RegHold, rnd);
      readReg(RegScLo, rd);
      checks++;
      if (rd !== scModel[31:0]) begin
         errors++;
         $display("[FAIL] RegScLo: got 0x%0h, expected 0x%0h", rd, scModel[31:0]);
      end
      readReg(RegScHi, rd);
      checks++;
      if (rd !== scModel[63:32]) begin
         errors++;
         $display("[FAIL] RegScHi: got 0x%0h, expected 0x%0h", rd, scModel[63:32]);
      end
      readReg(RegAcqTime, rd);
      checks++;
      if (rd !== {16'h0, acqModel}) begin
         errors++;
         $display("[FAIL] RegAcqTime: got 0x%0h, expected 0x%0h", rd, acqModel);
      end
      readReg(RegHold, rd);
      checks++;
      if (rd !== {16'h0, holdModel}) begin
         errors++;
         $display("[FAIL] RegHold: got 0x%0h, expected 0x%0h", rd, holdModel);
      end

      //////////////////////////////////////////////////
      // Slow-control load of the chain
      //////////////////////////////////////////////////
      scStream.delete();
      rstLow = 0;
      writeReg(RegCtrl, 32'h5);        // Load plus hold enable
      readReg(RegCtrl, rd);
      checks++;
      if (rd !== 32'h4) begin           // Start bits read as zero
         errors++;
         $display("[FAIL] RegCtrl: got 0x%0h, expected 0x4", rd);
      end
      polls = 0;
      do begin
         readReg(RegStatus, rd);
         polls++;
      end while (!rd[0] && polls < PollLimit);
      if (!rd[0]) reportTimeout("configDone in RegStatus");
      checks++;
      if (rstLow != 4) begin
         errors++;
         $display("[FAIL] srRstB low cycles: got 0x%0h, expected 0x4", rstLow);
      end
      checks++;
      if (scStream.size() != NumAsics * ScBits) begin
         errors++;
         $display("[FAIL] srCk edges: got 0x%0h, expected 0x%0h", scStream.size(),
                  NumAsics * ScBits);
      end
      mismatches = 0;
      for (int i = 0; i < scStream.size(); i++) begin
         checks++;
         if (scStream[i] !== scModel[ScBits-1 - (i % ScBits)]) begin   // Word repeats per chip
            errors++;
            mismatches++;
            if (mismatches < 4) $display("[FAIL] srIn bit %0d: got 0x%0h, expected 0x%0h", i,
                                         scStream[i], scModel[ScBits-1 - (i % ScBits)]);
         end
      end

      //////////////////////////////////////////////////
      // One acquisition cycle
      //////////////////////////////////////////////////
      readReg(RegEvtCount, evtBefore);
      acqLen = 4 + $urandom % 37;
      writeReg(RegAcqTime, acqLen);
      writeReg(RegCtrl, 32'h6);
      waitStartAcqLevel(1'b1);
      winCycles = 0;
      pwrBad    = 0;
      while (startAcq === 1'b1 && winCycles < StateTimeout) begin
         winCycles++;
         if (pwrOn !== 4'hF) pwrBad++;
         @(negedge Clk);
      end
      checks++;
      if (winCycles != acqLen) begin
         errors++;
         $display("[FAIL] startAcq width: got 0x%0h, expected 0x%0h", winCycles, acqLen);
      end
      checks++;
      if (pwrBad != 0) begin
         errors++;
         $display("[FAIL] pwrOn low during window in 0x%0h cycles, expected 0x0", pwrBad);
      end
      checks++;
      if (startReadout !== 1'b1) begin  // Rises as the window closes
         errors++;
         $display("[FAIL] startReadout after window: got 0x%0h, expected 0x1", startReadout);
      end
      @(negedge Clk);
      checks++;
      if (startReadout !== 1'b0 || pwrOn !== 4'hF) begin
         errors++;
         $display("[FAIL] startReadout/pwrOn: got 0x%0h/0x%0h, expected 0x0/0xf",
                  startReadout, pwrOn);
      end
      pulseEndReadout(1 + $urandom % 20);
      waitPowerOff();
      readReg(RegEvtCount, rd);
      checks++;
      if (rd !== evtBefore + 1) begin
         errors++;
         $display("[FAIL] RegEvtCount: got 0x%0h, expected 0x%0h", rd, evtBefore + 1);
      end

      //////////////////////////////////////////////////
      // Hold delay and width
      //////////////////////////////////////////////////
      holdDly = $urandom % 8;
      holdWid = 3 + $urandom % 6;      // Long enough to retrigger inside
      writeReg(RegHold, {16'h0, holdWid[7:0], holdDly[7:0]});
      writeReg(RegAcqTime, 32'd100);
      writeReg(RegCtrl, 32'h6);
      waitStartAcqLevel(1'b1);
      repeat (2 + $urandom % 8) @(posedge Clk);
      for (k = 0; k < HoldSpan; k++) begin
         @(posedge Clk);
         if (k == 0 || k == holdDly + 3) trigIn <= 1'b1;       // Second edge hits active hold
         else if (k == 2 || k == holdDly + 5) trigIn <= 1'b0;
         @(negedge Clk);
         holdExp = (k >= holdDly + 2) && (k < holdDly + 2 + holdWid);
         checks++;
         if (hold !== holdExp) begin
            errors++;
            $display("[FAIL] hold %0d cycles after trigger: got 0x%0h, expected 0x%0h",
                     k, hold, holdExp);
         end
      end
      waitStartAcqLevel(1'b0);
      @(posedge Clk);
      trigIn <= 1'b1;                   // Outside the window
      @(posedge Clk);
      trigIn <= 1'b0;
      holdSeen = 0;
      for (k = 0; k < HoldSpan; k++) begin
         @(negedge Clk);
         if (hold) holdSeen++;
      end
      checks++;
      if (holdSeen != 0) begin
         errors++;
         $display("[FAIL] hold outside window: got 0x%0h cycles high, expected 0x0", holdSeen);
      end
      pulseEndReadout(1 + $urandom % 20);
      waitPowerOff();

      //////////////////////////////////////////////////
      // RAM readout under FIFO back-pressure
      //////////////////////////////////////////////////
      rxWords.delete();
      txWords.delete();
      for (n = 0; n < NumWords; n++) begin
         w = rawWord_t'($urandom);
         txWords.push_back(w);
         sendSerialWord(w, 1'b0);
         gap = 1 + $urandom % 10;
         for (g = 0; g < gap; g++) begin
            @(posedge Clk);
            rnd = $urandom;
            transmitOnB <= 1'b1;
            fifoFull    <= rnd[0];      // Random stall between words
         end
      end
      @(posedge Clk);
      fifoFull <= 1'b0;
      polls = 0;
      while (rxWords.size() < NumWords && polls < StateTimeout) begin
         @(negedge Clk);
         polls++;
      end
      if (rxWords.size() < NumWords) reportTimeout("FIFO words");
      for (int i = 0; i < NumWords; i++) begin
         checks++;
         if (rxWords[i] !== txWords[i]) begin
            errors++;
            $display("[FAIL] fifoWord.data %0d: got 0x%0h, expected 0x%0h", i, rxWords[i],
                     txWords[i]);
         end
      end
      readReg(RegStatus, rd);
      checks++;
      if (rd[2] !== 1'b0) begin
         errors++;
         $display("[FAIL] overflow: got 0x%0h, expected 0x0", rd[2]);
      end
      // Burst into a full FIFO, second word finds the buffer taken
      for (n = 0; n < 3; n++) sendSerialWord(rawWord_t'($urandom), 1'b1);
      @(posedge Clk);
      transmitOnB <= 1'b1;
      repeat (2) @(posedge Clk);
      readReg(RegStatus, rd);
      checks++;
      if (rd[2] !== 1'b1) begin
         errors++;
         $display("[FAIL] overflow after burst: got 0x%0h, expected 0x1", rd[2]);
      end

      //////////////////////////////////////////////////
      // Host force reset of the DAQ path
      //////////////////////////////////////////////////
      writeReg(RegCtrl, 32'h8);
      @(negedge Clk);
      checks++;
      if (resetB !== 1'b0) begin        // ASIC reset pin held low
         errors++;
         $display("[FAIL] resetB under force reset: got 0x%0h, expected 0x0", resetB);
      end
      readReg(RegStatus, rd);
      checks++;
      if (rd[2] !== 1'b0) begin         // Sticky flag cleared
         errors++;
         $display("[FAIL] overflow under force reset: got 0x%0h, expected 0x0", rd[2]);
      end
      writeReg(RegCtrl, 32'h0);
      @(negedge Clk);
      checks++;
      if (resetB !== 1'b1) begin
         errors++;
         $display("[FAIL] resetB after force reset: got 0x%0h, expected 0x1", resetB);
      end

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: verification/microrocTop_props.sv
`timescale 1ns/10ps

module microrocTop_props import microrocPkg::*; (
   input logic      Clk,
   input logic      arstN,
   input wbRsp_t    wbRsp,
   input scPins_t   scPins,
   input logic      startAcq,
   input daqState_t daqState    // DAQ FSM state
);

   //////////////////////////////////////////////////
   // Bus and ASIC pin rules
   //////////////////////////////////////////////////
   ackOneCycle: assert property (@(posedge Clk) disable iff (!arstN)
      wbRsp.ack |=> !wbRsp.ack)
      else $error("Wishbone ack lasted more than one cycle");

   // Data moves only in the low phase of srCk
   srInStable: assert property (@(posedge Clk) disable iff (!arstN)
      scPins.srCk |-> $stable(scPins.srIn))
      else $error("srIn changed while srCk was high");

   acqInWindow: assert property (@(posedge Clk) disable iff (!arstN)
      $rose(startAcq) |-> daqState == Acquire)
      else $error("startAcq rose outside the Acquire state");

endmodule

bind microrocTop microrocTop_props iProps (
   .Clk      (Clk),
   .arstN    (arstN),
   .wbRsp    (wbRsp),
   .scPins   (scPins),
   .startAcq (startAcq),
   .daqState (iDaq.state)
);

// File: design/microrocTop.sv
`timescale 1ns/10ps

module microrocTop import microrocPkg::*; #(
   parameter int numAsics = 2                // Chips in the daisy chain
) (
   input  logic      Clk,
   input  logic      arstN,
   input  wbReq_t    wbReq,
   output wbRsp_t    wbRsp,
   // ASIC side
   output scPins_t   scPins,
   output pwrOn_t    pwrOn,
   output logic      startAcq,
   output logic      resetB,
   input  logic      chipSatB,
   output logic      startReadout,
   input  logic      endReadout,
   input  logic      doutB,
   input  logic      transmitOnB,
   input  logic      trigIn,
   output logic      hold,
   // External FIFO
   input  logic      fifoFull,
   output fifoWord_t fifoWord
);

   scWord_t   scWord;
   logic      loadStart, configDone;
   logic      acqStart, acqBusy, onceEnd;
   acqTime_t  acqTime;
   logic      holdEn;
   holdTime_t holdDelay, holdWidth;
   logic      overflow;
   logic      forceReset;
   logic      asicRstN;

   // Host force reset clears the DAQ path only
   assign asicRstN = arstN & ~forceReset;

   configRegs iRegs (
      .Clk        (Clk),
      .arstN      (arstN),
      .wbReq      (wbReq),
      .configDone (configDone),
      .acqBusy    (acqBusy),
      .onceEnd    (onceEnd),
      .overflow   (overflow),
      .wbRsp      (wbRsp),
      .scWord     (scWord),
      .loadStart  (loadStart),
      .acqStart   (acqStart),
      .acqTime    (acqTime),
      .holdEn     (holdEn),
      .holdDelay  (holdDelay),
      .holdWidth  (holdWidth),
      .forceReset (forceReset)
   );

   slowControlLoader #(.numAsics(numAsics)) iScLoader (
      .Clk        (Clk),
      .arstN      (arstN),
      .loadStart  (loadStart),
      .scWord     (scWord),
      .scPins     (scPins),
      .configDone (configDone)
   );

   daqControl iDaq (
      .Clk          (Clk),
      .arstN        (asicRstN),
      .forceReset   (forceReset),
      .acqStart     (acqStart),
      .acqTime      (acqTime),
      .chipSatB     (chipSatB),
      .endReadout   (endReadout),
      .pwrOn        (pwrOn),
      .startAcq     (startAcq),
      .resetB       (resetB),
      .startReadout (startReadout),
      .onceEnd      (onceEnd),
      .acqBusy      (acqBusy)
   );

   ramReadOut iRamRo (
      .Clk         (Clk),
      .arstN       (asicRstN),
      .forceReset  (forceReset),
      .doutB       (doutB),
      .transmitOnB (transmitOnB),
      .fifoFull    (fifoFull),
      .fifoWord    (fifoWord),
      .overflow    (overflow)
   );

   holdGen iHold (
      .Clk       (Clk),
      .arstN     (arstN),
      .trigIn    (trigIn),
      .holdEn    (holdEn),
      .startAcq  (startAcq),
      .holdDelay (holdDelay),
      .holdWidth (holdWidth),
      .hold      (hold)
   );

endmodule

// File: design/holdGen.sv
`timescale 1ns/10ps

module holdGen import microrocPkg::*; (
   input  logic      Clk,
   input  logic      arstN,
   input  logic      trigIn,
   input  logic      holdEn,
   input  logic      startAcq,   // Triggers count only in the window
   input  holdTime_t holdDelay,
   input  holdTime_t holdWidth,
   output logic      hold
);

   logic      trigQ;
   logic      trigEdge;
   logic      busy;             // Pending or active hold
   holdTime_t cnt;              // Delay, then width

   assign trigEdge = trigIn & ~trigQ;

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         trigQ <= 1'b0;
         busy  <= 1'b0;
         hold  <= 1'b0;
         cnt   <= '0;
      end else begin
         trigQ <= trigIn;
         if (!busy) begin
            if (trigEdge && holdEn && startAcq) begin
               busy <= 1'b1;
               cnt  <= holdDelay;
            end
         end else if (!hold) begin
            // Delay phase, hold rises delay+2 after the edge
            if (cnt == '0) begin
               hold <= (holdWidth != '0);
               busy <= (holdWidth != '0);
               cnt  <= holdWidth - 1'b1;
            end else begin
               cnt <= cnt - 1'b1;
            end
         end else begin
            if (cnt == '0) begin
               hold <= 1'b0;
               busy <= 1'b0;    // Re-arm
            end else begin
               cnt <= cnt - 1'b1;
            end
         end
      end
   end

endmodule

// File: design/ramReadOut.sv
`timescale 1ns/10ps

module ramReadOut import microrocPkg::*; (
   input  logic      Clk,
   input  logic      arstN,        // Already gated with force reset
   input  logic      forceReset,
   input  logic      doutB,        // Active low serial data
   input  logic      transmitOnB,  // Active low frame
   input  logic      fifoFull,
   output fifoWord_t fifoWord,
   output logic      overflow      // Sticky
);

   rawWord_t   shReg, bufWord, outData;
   logic [3:0] bitCnt;
   logic       sampleEn;
   logic       wordRdy;            // shReg holds a full word
   logic       bufValid, outValid;

   assign sampleEn = ~transmitOnB & ~forceReset;
   assign fifoWord = '{valid: outValid, data: outData};

   // MSB first, inverted
   always_ff @(posedge Clk) begin
      if (sampleEn) shReg <= {shReg[14:0], ~doutB};
   end

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         bitCnt  <= '0;
         wordRdy <= 1'b0;
      end else begin
         wordRdy <= sampleEn && bitCnt == 4'd15;
         if (sampleEn) bitCnt <= bitCnt + 1'b1;
         else          bitCnt <= '0;    // Frame ended, drop partial word
      end
   end

   //////////////////////////////////////////////////
   // Back-pressure buffer
   //////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         outValid <= 1'b0;
         bufValid <= 1'b0;
         overflow <= 1'b0;
      end else begin
         outValid <= 1'b0;
         if (bufValid && !fifoFull) begin
            outValid <= 1'b1;           // Buffered word goes first
            bufValid <= wordRdy;
         end else if (wordRdy && !bufValid && !fifoFull) begin
            outValid <= 1'b1;
         end else if (wordRdy && !bufValid) begin
            bufValid <= 1'b1;
         end else if (wordRdy) begin
            overflow <= 1'b1;           // New word lost
         end
      end
   end

   always_ff @(posedge Clk) begin
      if (bufValid && !fifoFull)          outData <= bufWord;
      else if (wordRdy && !fifoFull)      outData <= shReg;
      if (wordRdy && (!bufValid || !fifoFull)) bufWord <= shReg;
   end

endmodule

// File: design/daqControl.sv
`timescale 1ns/10ps

module daqControl import microrocPkg::*; (
   input  logic     Clk,
   input  logic     arstN,          // Already gated with force reset
   input  logic     forceReset,
   input  logic     acqStart,
   input  acqTime_t acqTime,
   input  logic     chipSatB,       // Low when chip memory is full
   input  logic     endReadout,
   output pwrOn_t   pwrOn,
   output logic     startAcq,
   output logic     resetB,
   output logic     startReadout,
   output logic     onceEnd,
   output logic     acqBusy
);

   localparam int PwrUpCycles = 4;  // Settling after power enables

   daqState_t state;
   acqTime_t  winCnt;               // Power-up and window counter

   // ASIC reset pin held low by either reset source
   assign resetB  = arstN & ~forceReset;
   assign acqBusy = (state != Idle);

   //////////////////////////////////////////////////
   // Acquisition sequence
   //////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         state        <= Idle;
         winCnt       <= '0;
         pwrOn        <= '0;
         startAcq     <= 1'b0;
         startReadout <= 1'b0;
         onceEnd      <= 1'b0;
      end else begin
         case (state)
            Idle: begin
               if (acqStart) begin
                  pwrOn  <= '1;             // All domains on before the window
                  winCnt <= '0;
                  state  <= PowerUp;
               end
            end
            PowerUp: begin
               winCnt <= winCnt + 1'b1;
               if (winCnt == acqTime_t'(PwrUpCycles - 1)) begin
                  winCnt   <= '0;
                  startAcq <= 1'b1;
                  state    <= Acquire;
               end
            end
            Acquire: begin
               winCnt <= winCnt + 1'b1;
               // Window closes at acqTime or on saturation
               if ((winCnt + 1'b1) >= acqTime || !chipSatB) begin
                  startAcq     <= 1'b0;
                  startReadout <= 1'b1;
                  state        <= StartRo;
               end
            end
            StartRo: begin
               startReadout <= 1'b0;        // Single-cycle pulse
               state        <= WaitEnd;
            end
            WaitEnd: begin
               if (endReadout) begin
                  pwrOn   <= '0;            // Power off after readout
                  onceEnd <= 1'b1;
                  state   <= Done;
               end
            end
            Done: begin
               onceEnd <= 1'b0;
               state   <= Idle;
            end
            default: state <= Idle;
         endcase
      end
   end

endmodule

// File: design/slowControlLoader.sv
`timescale 1ns/10ps

module slowControlLoader import microrocPkg::*; #(
   parameter int numAsics = 2
) (
   input  logic    Clk,
   input  logic    arstN,
   input  logic    loadStart,
   input  scWord_t scWord,
   output scPins_t scPins,
   output logic    configDone
);

   localparam int TotalBits = numAsics * ScBits;   // Whole chain
   localparam int CntW      = $clog2(TotalBits);

   typedef enum logic [1:0] {ScIdle, ScReset, ScShift, ScFinish} scState_t;

   scState_t  state;
   scWord_t   shiftReg;
   logic [1:0] divCnt;            // Reset length, then srCk phase
   logic [CntW-1:0] bitCnt;

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         state      <= ScIdle;
         divCnt     <= '0;
         bitCnt     <= '0;
         scPins     <= '{select: 1'b0, srRstB: 1'b1, srCk: 1'b0, srIn: 1'b0};
         configDone <= 1'b0;
      end else begin
         case (state)
            ScIdle: begin
               if (loadStart) begin
                  scPins.select <= 1'b1;
                  scPins.srRstB <= 1'b0;   // Chain register reset
                  configDone    <= 1'b0;
                  divCnt        <= '0;
                  bitCnt        <= '0;
                  state         <= ScReset;
               end
            end
            ScReset: begin
               divCnt <= divCnt + 1'b1;    // 4 cycles low
               if (divCnt == 2'd3) begin
                  scPins.srRstB <= 1'b1;
                  state         <= ScShift;
               end
            end
            ScShift: begin
               divCnt <= divCnt + 1'b1;
               case (divCnt)
                  2'd0: scPins.srIn <= shiftReg[ScBits-1];   // Data while srCk low
                  2'd1: scPins.srCk <= 1'b1;                 // Rising edge
                  2'd3: begin
                     scPins.srCk <= 1'b0;
                     bitCnt      <= bitCnt + 1'b1;
                     if (bitCnt == CntW'(TotalBits - 1)) state <= ScFinish;
                  end
                  default: ;
               endcase
            end
            ScFinish: begin
               scPins.select <= 1'b0;
               scPins.srIn   <= 1'b0;
               configDone    <= 1'b1;      // Held until next load
               state         <= ScIdle;
            end
            default: state <= ScIdle;
         endcase
      end
   end

   // Rotate so the same word repeats for every chip
   always_ff @(posedge Clk) begin
      if (state == ScIdle && loadStart) begin
         shiftReg <= scWord;
      end else if (state == ScShift && divCnt == 2'd3) begin
         shiftReg <= {shiftReg[ScBits-2:0], shiftReg[ScBits-1]};
      end
   end

endmodule

// File: design/configRegs.sv
`timescale 1ns/10ps

module configRegs import microrocPkg::*; (
   input  logic      Clk,
   input  logic      arstN,
   input  wbReq_t    wbReq,
   input  logic      configDone,
   input  logic      acqBusy,
   input  logic      onceEnd,
   input  logic      overflow,
   output wbRsp_t    wbRsp,
   output scWord_t   scWord,
   output logic      loadStart,   // One-cycle pulse
   output logic      acqStart,    // One-cycle pulse
   output acqTime_t  acqTime,
   output logic      holdEn,
   output holdTime_t holdDelay,
   output holdTime_t holdWidth,
   output logic      forceReset
);

   logic     ackQ;
   logic     access, wrEn;
   regData_t rdMux, rdData;
   regData_t evtCount;

   // New access only when no ack is pending
   assign access = wbReq.cyc & wbReq.stb & ~ackQ;
   assign wrEn   = access & wbReq.we;

   assign wbRsp = '{ack: ackQ, dat: rdData};

   //////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////
   always_comb begin
      rdMux = '0;
      case (wbReq.adr)
         RegCtrl:     rdMux[3:2]  = {forceReset, holdEn};   // Start bits read 0
         RegStatus:   rdMux[2:0]  = {overflow, acqBusy, configDone};
         RegScLo:     rdMux       = scWord[31:0];
         RegScHi:     rdMux       = scWord[63:32];
         RegAcqTime:  rdMux[15:0] = acqTime;
         RegHold:     rdMux[15:0] = {holdWidth, holdDelay};
         RegEvtCount: rdMux       = evtCount;
         default:     rdMux       = '0;
      endcase
   end

   always_ff @(posedge Clk) begin
      if (access) rdData <= rdMux;               // Valid with ack
   end

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         ackQ <= 1'b0;
      end else begin
         ackQ <= access;                         // Exactly one cycle
      end
   end

   //////////////////////////////////////////////////
   // Write path
   //////////////////////////////////////////////////
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         scWord     <= '0;
         acqTime    <= 16'd8;
         holdDelay  <= 8'd4;
         holdWidth  <= 8'd8;
         holdEn     <= 1'b0;
         forceReset <= 1'b0;
         loadStart  <= 1'b0;
         acqStart   <= 1'b0;
      end else begin
         loadStart <= 1'b0;                      // Pulses self-clear
         acqStart  <= 1'b0;
         if (wrEn) begin
            case (wbReq.adr)
               RegCtrl: begin
                  loadStart  <= wbReq.dat[0];
                  acqStart   <= wbReq.dat[1];
                  holdEn     <= wbReq.dat[2];
                  forceReset <= wbReq.dat[3];
               end
               RegScLo:    scWord[31:0]  <= wbReq.dat;
               RegScHi:    scWord[63:32] <= wbReq.dat;
               RegAcqTime: acqTime       <= wbReq.dat[15:0];
               RegHold: begin
                  holdDelay <= wbReq.dat[7:0];
                  holdWidth <= wbReq.dat[15:8];
               end
               default: ;                        // Status and count are read only
            endcase
         end
      end
   end

   // Completed acquisition cycles
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         evtCount <= '0;
      end else if (onceEnd) begin
         evtCount <= evtCount + 1'b1;
      end
   end

endmodule

// File: design/microrocPkg.sv
package microrocPkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////
   localparam int ScBits = 64;              // Config bits per chip

   typedef logic [ScBits-1:0] scWord_t;     // One chip's slow-control word
   typedef logic [2:0]        regAddr_t;    // Wishbone word address
   typedef logic [31:0]       regData_t;
   typedef logic [15:0]       acqTime_t;    // Window length in Clk cycles
   typedef logic [7:0]        holdTime_t;   // Hold delay or width
   typedef logic [15:0]       rawWord_t;    // Deserialized RAM word

   // Register map
   localparam regAddr_t RegCtrl     = 3'd0; // Load, acq, hold enable, force reset
   localparam regAddr_t RegStatus   = 3'd1; // Read only
   localparam regAddr_t RegScLo     = 3'd2;
   localparam regAddr_t RegScHi     = 3'd3;
   localparam regAddr_t RegAcqTime  = 3'd4;
   localparam regAddr_t RegHold     = 3'd5; // Delay 7..0, width 15..8
   localparam regAddr_t RegEvtCount = 3'd6; // Completed cycles

   //////////////////////////////////////////////////
   // Port bundles
   //////////////////////////////////////////////////
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      regAddr_t adr;
      regData_t dat;
   } wbReq_t;

   typedef struct packed {
      logic     ack;
      regData_t dat;
   } wbRsp_t;

   // Slow-control pins towards the chain
   typedef struct packed {
      logic select;
      logic srRstB;
      logic srCk;
      logic srIn;
   } scPins_t;

   typedef struct packed {
      logic d;
      logic a;
      logic adc;
      logic dac;
   } pwrOn_t;

   typedef struct packed {
      logic     valid;
      rawWord_t data;
   } fifoWord_t;

   typedef enum logic [2:0] {
      Idle, PowerUp, Acquire, StartRo, WaitEnd, Done
   } daqState_t;

endpackage
